// File: logic/packet_pkg.sv
// Host packet interface shared definitions
// Link widths, host opcodes, outgoing message kinds with their header
// bytes, and the structs for input fires and messages to the host
package packet_pkg;

    localparam int BYTE_W = 8;
    localparam int TIME_W = 32;

    // Host opcodes
    // A byte with bit 7 set is an input fire and carries the neuron address
    typedef enum logic [BYTE_W-1:0] {
        OP_NOOP    = 8'h00,
        OP_STEP    = 8'h01,
        OP_METRIC  = 8'h02,
        OP_CLR_ACT = 8'h04
    } opcode_e;

    // Messages to the host
    typedef enum logic [1:0] {
        MSG_TIME,
        MSG_FIRE,
        MSG_METRIC,
        MSG_CLEAR_ACK
    } msg_kind_e;

    // Header byte that opens each message
    localparam logic [BYTE_W-1:0] HDR_TIME      = 8'h01;
    localparam logic [BYTE_W-1:0] HDR_FIRE      = 8'h80;
    localparam logic [BYTE_W-1:0] HDR_METRIC    = 8'h02;
    localparam logic [BYTE_W-1:0] HDR_CLEAR_ACK = 8'h0C;

    // Payload is filled from the low end and sent most significant byte first
    //   MSG_TIME      all four bytes
    //   MSG_FIRE      low byte only
    //   MSG_METRIC    bits 15:8 address, bits 7:0 value
    //   MSG_CLEAR_ACK no payload
    typedef struct packed {
        msg_kind_e         kind;
        logic [TIME_W-1:0] payload;
    } tx_msg_t;

    // Input fire handed to the core
    typedef struct packed {
        logic [BYTE_W-1:0] addr;
        logic [BYTE_W-1:0] value;
    } fire_t;

endpackage

// File: logic/rx_decoder.sv
// Receive decoder
// Parses host packets one byte at a time and turns them into core
// requests (input fire, step, metric read, activity clear). Builds the
// metric reply and the clear acknowledge for the transmit link.
module rx_decoder (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [packet_pkg::BYTE_W-1:0] rx_data,
    input  logic                          rx_valid,
    output logic                          rx_ready,

    output packet_pkg::fire_t             fire,
    output logic                          fire_valid,
    input  logic                          fire_ready,

    output logic [packet_pkg::BYTE_W-1:0] step_count,
    output logic                          step_valid,
    input  logic                          step_ready,

    output logic [packet_pkg::BYTE_W-1:0] metric_addr,
    output logic                          metric_req_valid,
    input  logic                          metric_req_ready,
    input  logic [packet_pkg::BYTE_W-1:0] metric_value,
    input  logic                          metric_resp_valid,

    output logic                          clear_act,
    input  logic                          clear_done,

    output packet_pkg::tx_msg_t           rx_msg,
    output logic                          rx_msg_valid,
    input  logic                          rx_msg_ready
);
    import packet_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_OPERAND,
        RX_FIRE_OUT,
        RX_STEP_OUT,
        RX_METRIC_REQ,
        RX_METRIC_WAIT,
        RX_CLEAR,
        RX_REPLY
    } rx_state_e;

    rx_state_e         state;
    logic [BYTE_W-1:0] opcode_q;
    logic [BYTE_W-1:0] operand_q;
    logic [BYTE_W-1:0] value_q;
    msg_kind_e         reply_kind;
    logic              rx_take;
    logic              metric_capture;

    assign rx_take = rx_valid && rx_ready;

    // Core may answer in the same cycle it takes the request
    assign metric_capture = metric_resp_valid &&
                            ((state == RX_METRIC_WAIT) ||
                             (state == RX_METRIC_REQ && metric_req_ready));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (rx_take) begin
                        if (rx_data[7]) begin
                            state <= RX_OPERAND;
                        end else begin
                            case (rx_data)
                                OP_STEP,
                                OP_METRIC:  state <= RX_OPERAND;
                                OP_CLR_ACT: state <= RX_CLEAR;
                                OP_NOOP:    state <= RX_IDLE;
                                // Unknown opcodes are dropped
                                default:    state <= RX_IDLE;
                            endcase
                        end
                    end
                end
                RX_OPERAND: begin
                    if (rx_take) begin
                        if (opcode_q[7]) begin
                            state <= RX_FIRE_OUT;
                        end else if (opcode_q == OP_STEP) begin
                            state <= RX_STEP_OUT;
                        end else begin
                            state <= RX_METRIC_REQ;
                        end
                    end
                end
                RX_FIRE_OUT: begin
                    if (fire_ready) begin
                        state <= RX_IDLE;
                    end
                end
                RX_STEP_OUT: begin
                    if (step_ready) begin
                        state <= RX_IDLE;
                    end
                end
                RX_METRIC_REQ: begin
                    if (metric_req_ready) begin
                        state <= metric_resp_valid ? RX_REPLY : RX_METRIC_WAIT;
                    end
                end
                RX_METRIC_WAIT: begin
                    if (metric_resp_valid) begin
                        state <= RX_REPLY;
                    end
                end
                RX_CLEAR: begin
                    if (clear_done) begin
                        state <= RX_REPLY;
                    end
                end
                RX_REPLY: begin
                    if (rx_msg_ready) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_IDLE && rx_take) begin
            opcode_q <= rx_data;
        end
        if (state == RX_OPERAND && rx_take) begin
            operand_q <= rx_data;
        end
        if (metric_capture) begin
            value_q <= metric_value;
        end
        if (state == RX_METRIC_REQ) begin
            reply_kind <= MSG_METRIC;
        end else if (state == RX_CLEAR) begin
            reply_kind <= MSG_CLEAR_ACK;
        end
    end

    assign rx_ready = (state == RX_IDLE) || (state == RX_OPERAND);

    // Fire address is the low seven bits of the opcode byte
    assign fire.addr  = {1'b0, opcode_q[6:0]};
    assign fire.value = operand_q;
    assign fire_valid = (state == RX_FIRE_OUT);

    assign step_count = operand_q;
    assign step_valid = (state == RX_STEP_OUT);

    assign metric_addr      = operand_q;
    assign metric_req_valid = (state == RX_METRIC_REQ);

    assign clear_act = (state == RX_CLEAR);

    assign rx_msg.kind    = reply_kind;
    assign rx_msg.payload = {{(TIME_W - 2 * BYTE_W){1'b0}}, operand_q, value_q};
    assign rx_msg_valid   = (state == RX_REPLY);

endmodule

// File: logic/event_reporter.sv
// Core event reporter
// Buffers one time update and one output fire from the core and offers
// them to the transmit link as messages, time report first
module event_reporter (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [packet_pkg::BYTE_W-1:0] out_fire_addr,
    input  logic                          out_fire_valid,
    output logic                          out_fire_ready,

    input  logic [packet_pkg::TIME_W-1:0] time_current,
    input  logic                          time_update,
    output logic                          time_ready,

    output packet_pkg::tx_msg_t           ev_msg,
    output logic                          ev_msg_valid,
    input  logic                          ev_msg_ready
);
    import packet_pkg::*;

    logic              time_pend;
    logic              fire_pend;
    logic [TIME_W-1:0] time_q;
    logic [BYTE_W-1:0] fire_addr_q;
    logic              held;
    logic              held_fire;
    logic              show_fire;
    logic              ev_take;

    assign time_ready     = !time_pend;
    assign out_fire_ready = !fire_pend;

    // An offer that was not taken keeps its kind until the transfer
    assign show_fire    = held ? held_fire : !time_pend;
    assign ev_msg_valid = time_pend || fire_pend;
    assign ev_take      = ev_msg_valid && ev_msg_ready;

    assign ev_msg.kind    = show_fire ? MSG_FIRE : MSG_TIME;
    assign ev_msg.payload = show_fire ? {{(TIME_W - BYTE_W){1'b0}}, fire_addr_q} : time_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            time_pend <= 1'b0;
            fire_pend <= 1'b0;
            held      <= 1'b0;
            held_fire <= 1'b0;
        end else begin
            if (time_update && time_ready) begin
                time_pend <= 1'b1;
            end else if (ev_take && !show_fire) begin
                time_pend <= 1'b0;
            end
            if (out_fire_valid && out_fire_ready) begin
                fire_pend <= 1'b1;
            end else if (ev_take && show_fire) begin
                fire_pend <= 1'b0;
            end
            held      <= ev_msg_valid && !ev_msg_ready;
            held_fire <= show_fire;
        end
    end

    // Snapshot of network time and fire address at acceptance
    always_ff @(posedge clk) begin
        if (time_update && time_ready) begin
            time_q <= time_current;
        end
        if (out_fire_valid && out_fire_ready) begin
            fire_addr_q <= out_fire_addr;
        end
    end

endmodule

// File: logic/tx_link_arbiter.sv
// Transmit link arbiter
// Grants the host transmit link to the event reporter ahead of the
// receive decoder, latches the winning message and serializes it as a
// header byte followed by its payload bytes, most significant first
module tx_link_arbiter (
    input  logic                          clk,
    input  logic                          reset,

    input  packet_pkg::tx_msg_t           rx_msg,
    input  logic                          rx_msg_valid,
    output logic                          rx_msg_ready,

    input  packet_pkg::tx_msg_t           ev_msg,
    input  logic                          ev_msg_valid,
    output logic                          ev_msg_ready,

    output logic [packet_pkg::BYTE_W-1:0] tx_data,
    output logic                          tx_valid,
    input  logic                          tx_ready
);
    import packet_pkg::*;

    logic       busy;
    tx_msg_t    msg_q;
    logic [2:0] byte_idx;
    logic [2:0] last_idx;
    logic [2:0] remaining;
    logic       ev_take;
    logic       rx_take;
    logic       tx_take;

    function automatic logic [2:0] payload_bytes(msg_kind_e kind);
        case (kind)
            MSG_TIME:   payload_bytes = 3'd4;
            MSG_FIRE:   payload_bytes = 3'd1;
            MSG_METRIC: payload_bytes = 3'd2;
            default:    payload_bytes = 3'd0;
        endcase
    endfunction

    function automatic logic [BYTE_W-1:0] header_byte(msg_kind_e kind);
        case (kind)
            MSG_TIME:   header_byte = HDR_TIME;
            MSG_FIRE:   header_byte = HDR_FIRE;
            MSG_METRIC: header_byte = HDR_METRIC;
            default:    header_byte = HDR_CLEAR_ACK;
        endcase
    endfunction

    // Reporter wins, which keeps time and fires ahead of replies
    assign ev_msg_ready = !busy;
    assign rx_msg_ready = !busy && !ev_msg_valid;

    assign ev_take = ev_msg_valid && ev_msg_ready;
    assign rx_take = rx_msg_valid && rx_msg_ready;

    assign tx_valid = busy;
    assign tx_take  = tx_valid && tx_ready;

    // Byte 0 is the header, byte k of n is payload byte n-k
    assign last_idx  = payload_bytes(msg_q.kind);
    assign remaining = last_idx - byte_idx;

    assign tx_data = (byte_idx == 3'd0) ? header_byte(msg_q.kind) :
                     msg_q.payload[{remaining[1:0], 3'b000} +: BYTE_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            byte_idx <= 3'd0;
        end else if (!busy) begin
            byte_idx <= 3'd0;
            if (ev_take || rx_take) begin
                busy <= 1'b1;
            end
        end else if (tx_take) begin
            if (byte_idx == last_idx) begin
                busy <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ev_take) begin
            msg_q <= ev_msg;
        end else if (rx_take) begin
            msg_q <= rx_msg;
        end
    end

endmodule

// File: logic/packet_interface.sv
// Host packet interface top level
// Connects the receive decoder and the event reporter, the two message
// sources, to the transmit link arbiter that drives the host byte stream
module packet_interface (
    input  logic                          clk,
    input  logic                          reset,

    // Host receive and transmit byte streams
    input  logic [packet_pkg::BYTE_W-1:0] rx_data,
    input  logic                          rx_valid,
    output logic                          rx_ready,
    output logic [packet_pkg::BYTE_W-1:0] tx_data,
    output logic                          tx_valid,
    input  logic                          tx_ready,

    // Requests to the core
    output packet_pkg::fire_t             fire,
    output logic                          fire_valid,
    input  logic                          fire_ready,
    output logic [packet_pkg::BYTE_W-1:0] step_count,
    output logic                          step_valid,
    input  logic                          step_ready,
    output logic [packet_pkg::BYTE_W-1:0] metric_addr,
    output logic                          metric_req_valid,
    input  logic                          metric_req_ready,
    input  logic [packet_pkg::BYTE_W-1:0] metric_value,
    input  logic                          metric_resp_valid,
    output logic                          clear_act,
    input  logic                          clear_done,

    // Events from the core
    input  logic [packet_pkg::BYTE_W-1:0] out_fire_addr,
    input  logic                          out_fire_valid,
    output logic                          out_fire_ready,
    input  logic [packet_pkg::TIME_W-1:0] time_current,
    input  logic                          time_update,
    output logic                          time_ready
);
    import packet_pkg::*;

    tx_msg_t rx_msg;
    logic    rx_msg_valid;
    logic    rx_msg_ready;
    tx_msg_t ev_msg;
    logic    ev_msg_valid;
    logic    ev_msg_ready;

    rx_decoder u_rx_decoder (
        .clk               (clk),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rx_ready          (rx_ready),
        .fire              (fire),
        .fire_valid        (fire_valid),
        .fire_ready        (fire_ready),
        .step_count        (step_count),
        .step_valid        (step_valid),
        .step_ready        (step_ready),
        .metric_addr       (metric_addr),
        .metric_req_valid  (metric_req_valid),
        .metric_req_ready  (metric_req_ready),
        .metric_value      (metric_value),
        .metric_resp_valid (metric_resp_valid),
        .clear_act         (clear_act),
        .clear_done        (clear_done),
        .rx_msg            (rx_msg),
        .rx_msg_valid      (rx_msg_valid),
        .rx_msg_ready      (rx_msg_ready)
    );

    event_reporter u_event_reporter (
        .clk            (clk),
        .reset          (reset),
        .out_fire_addr  (out_fire_addr),
        .out_fire_valid (out_fire_valid),
        .out_fire_ready (out_fire_ready),
        .time_current   (time_current),
        .time_update    (time_update),
        .time_ready     (time_ready),
        .ev_msg         (ev_msg),
        .ev_msg_valid   (ev_msg_valid),
        .ev_msg_ready   (ev_msg_ready)
    );

    tx_link_arbiter u_tx_link_arbiter (
        .clk          (clk),
        .reset        (reset),
        .rx_msg       (rx_msg),
        .rx_msg_valid (rx_msg_valid),
        .rx_msg_ready (rx_msg_ready),
        .ev_msg       (ev_msg),
        .ev_msg_valid (ev_msg_valid),
        .ev_msg_ready (ev_msg_ready),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready)
    );

endmodule

// File: dv/packet_interface_checker.sv
// Handshake checker for the host packet interface
// Bound to the top level. Flags transmit bytes that change before they
// are accepted, core requests that drop early, and host bytes taken
// while a core request is pending
module packet_interface_checker (
    input logic                          clk,
    input logic                          reset,
    input logic [packet_pkg::BYTE_W-1:0] tx_data,
    input logic                          tx_valid,
    input logic                          tx_ready,
    input logic                          fire_valid,
    input logic                          fire_ready,
    input logic                          step_valid,
    input logic                          step_ready,
    input logic                          metric_req_valid,
    input logic                          metric_req_ready,
    input logic                          clear_act,
    input logic                          rx_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    tx_held: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else $error("tx byte dropped or changed before it was accepted");

    fire_held: assert property (@(posedge clk) disable iff (reset)
        fire_valid && !fire_ready |=> fire_valid)
        else $error("fire_valid dropped before it was accepted");

    step_held: assert property (@(posedge clk) disable iff (reset)
        step_valid && !step_ready |=> step_valid)
        else $error("step_valid dropped before it was accepted");

    metric_held: assert property (@(posedge clk) disable iff (reset)
        metric_req_valid && !metric_req_ready |=> metric_req_valid)
        else $error("metric_req_valid dropped before it was accepted");

    // No host byte may be taken while the core is busy with a request
    rx_blocked: assert property (@(posedge clk) disable iff (reset)
        (fire_valid || step_valid || metric_req_valid || clear_act) |-> !rx_ready)
        else $error("rx_ready high while a core request is pending");

endmodule

// File: dv/packet_interface_tb.sv
// Host packet interface testbench
// Directed tests for input fires, steps, metric reads, activity clears,
// core event reports and unknown opcodes, with random core and host
// back-pressure
module packet_interface_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import packet_pkg::*;

    localparam int TIMEOUT    = 200;
    localparam int LOG_FIRE   = 0;
    localparam int LOG_STEP   = 1;
    localparam int LOG_METRIC = 2;
    localparam int LOG_TX     = 3;

    logic              clk;
    logic              reset;
    logic [BYTE_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic [BYTE_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready = 1'b1;
    fire_t             fire;
    logic              fire_valid;
    logic              fire_ready = 1'b0;
    logic [BYTE_W-1:0] step_count;
    logic              step_valid;
    logic              step_ready = 1'b0;
    logic [BYTE_W-1:0] metric_addr;
    logic              metric_req_valid;
    logic              metric_req_ready = 1'b0;
    logic [BYTE_W-1:0] metric_value;
    logic              metric_resp_valid;
    logic              clear_act;
    logic              clear_done;
    logic [BYTE_W-1:0] out_fire_addr;
    logic              out_fire_valid;
    logic              out_fire_ready;
    logic [TIME_W-1:0] time_current;
    logic              time_update;
    logic              time_ready;

    logic [7:0]        lfsr = 8'd91;
    int                fire_delay = -1;
    int                step_delay = -1;
    int                metric_delay = -1;
    int                checks;
    int                errors;
    int                test_errors;
    fire_t             fire_log[$];
    logic [BYTE_W-1:0] step_log[$];
    logic [BYTE_W-1:0] metric_log[$];
    logic [BYTE_W-1:0] tx_log[$];
    logic [BYTE_W-1:0] tx_expect[$];

    packet_interface DUT (.*);

    bind packet_interface packet_interface_checker u_checker (
        .clk              (clk),
        .reset            (reset),
        .tx_data          (tx_data),
        .tx_valid         (tx_valid),
        .tx_ready         (tx_ready),
        .fire_valid       (fire_valid),
        .fire_ready       (fire_ready),
        .step_valid       (step_valid),
        .step_ready       (step_ready),
        .metric_req_valid (metric_req_valid),
        .metric_req_ready (metric_req_ready),
        .clear_act        (clear_act),
        .rx_ready         (rx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    // Core accepts a request 0 to 3 cycles after it sees it
    task automatic model_core_ready(input logic valid, inout logic ready, inout int delay);
        if (reset || ready || valid !== 1'b1) begin
            ready = 1'b0;
            delay = -1;
        end else begin
            if (delay < 0) begin
                delay = rand_bits(2);
            end
            if (delay == 0) begin
                ready = 1'b1;
            end else begin
                delay--;
            end
        end
    endtask

    always @(negedge clk) begin
        model_core_ready(fire_valid, fire_ready, fire_delay);
        model_core_ready(step_valid, step_ready, step_delay);
        model_core_ready(metric_req_valid, metric_req_ready, metric_delay);
        if (!reset) begin
            tx_ready = (rand_bits(2) != 0);
        end
    end

    // Transfers are logged on the rising edge where they happen
    always @(posedge clk) begin
        if (!reset) begin
            if (fire_valid && fire_ready) begin
                fire_log.push_back(fire);
            end
            if (step_valid && step_ready) begin
                step_log.push_back(step_count);
            end
            if (metric_req_valid && metric_req_ready) begin
                metric_log.push_back(metric_addr);
            end
            if (tx_valid && tx_ready) begin
                tx_log.push_back(tx_data);
            end
        end
    end

    function automatic int log_size(input int which);
        case (which)
            LOG_FIRE:   return fire_log.size();
            LOG_STEP:   return step_log.size();
            LOG_METRIC: return metric_log.size();
            default:    return tx_log.size();
        endcase
    endfunction

    task automatic wait_for_log(input int which, input int n, input string what);
        int cycles;
        cycles = 0;
        while (log_size(which) < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (log_size(which) < n) begin
            errors++;
            $display("Timed out waiting for %s", what);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input logic [BYTE_W-1:0] value);
        int cycles;
        cycles   = 0;
        rx_data  = value;
        rx_valid = 1'b1;
        while (!rx_ready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rx_ready) begin
            errors++;
            $display("The DUT never accepted host byte %h", value);
        end
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] expected,
                              input logic [BYTE_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_fire(input fire_t expected, input fire_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED fire expected 0x%h got 0x%h", expected, actual);
        end
    endtask

    task automatic check_msg_bytes(input string name);
        check_count({name, " byte count"}, tx_expect.size(), tx_log.size());
        for (int i = 0; i < tx_expect.size() && i < tx_log.size(); i++) begin
            check_byte($sformatf("%s tx_data[%0d]", name, i), tx_expect[i], tx_log[i]);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
        fire_log.delete();
        step_log.delete();
        metric_log.delete();
        tx_log.delete();
        tx_expect.delete();
    endtask

    task automatic test_fire(input logic [6:0] addr, input logic [BYTE_W-1:0] value);
        fire_t expected;
        expected.addr  = {1'b0, addr};
        expected.value = value;
        send_byte({1'b1, addr});
        send_byte(value);
        wait_for_log(LOG_FIRE, 1, "the input fire");
        repeat (6) @(negedge clk);
        check_count("fire transfers", 1, fire_log.size());
        if (fire_log.size() > 0) begin
            check_fire(expected, fire_log[0]);
        end
        end_test("input fire");
    endtask

    task automatic test_step(input logic [BYTE_W-1:0] n);
        send_byte(OP_STEP);
        send_byte(n);
        wait_for_log(LOG_STEP, 1, "the step request");
        repeat (6) @(negedge clk);
        check_count("step transfers", 1, step_log.size());
        if (step_log.size() > 0) begin
            check_byte("step_count", n, step_log[0]);
        end
        check_msg_bytes("step tx");
        end_test("step");
    endtask

    task automatic test_metric(input logic [BYTE_W-1:0] addr, input logic [BYTE_W-1:0] value);
        send_byte(OP_METRIC);
        send_byte(addr);
        wait_for_log(LOG_METRIC, 1, "the metric request");
        if (metric_log.size() > 0) begin
            check_byte("metric_addr", addr, metric_log[0]);
        end
        metric_value      = value;
        metric_resp_valid = 1'b1;
        @(negedge clk);
        metric_resp_valid = 1'b0;
        tx_expect.push_back(HDR_METRIC);
        tx_expect.push_back(addr);
        tx_expect.push_back(value);
        wait_for_log(LOG_TX, 3, "the metric reply");
        check_msg_bytes("metric reply");
        end_test("metric read");
    endtask

    task automatic test_clear();
        int cycles;
        cycles = 0;
        send_byte(OP_CLR_ACT);
        while (!clear_act && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!clear_act) begin
            errors++;
            $display("clear_act never rose after the clear opcode");
        end
        // Level holds for as long as the core takes to finish
        repeat (rand_bits(2) + 1) begin
            @(negedge clk);
            check_byte("clear_act", 8'h01, {7'b0, clear_act});
        end
        clear_done = 1'b1;
        @(negedge clk);
        clear_done = 1'b0;
        check_byte("clear_act", 8'h00, {7'b0, clear_act});
        tx_expect.push_back(HDR_CLEAR_ACK);
        wait_for_log(LOG_TX, 1, "the clear acknowledge");
        repeat (4) @(negedge clk);
        check_msg_bytes("clear ack");
        end_test("clear");
    endtask

    task automatic test_reports(input logic [TIME_W-1:0] now, input logic [BYTE_W-1:0] addr);
        int  cycles;
        logic time_taken;
        logic fire_taken;
        cycles         = 0;
        time_current   = now;
        time_update    = 1'b1;
        out_fire_addr  = addr;
        out_fire_valid = 1'b1;
        while ((time_update || out_fire_valid) && cycles < TIMEOUT) begin
            time_taken = time_ready;
            fire_taken = out_fire_ready;
            @(negedge clk);
            if (time_taken) begin
                time_update = 1'b0;
            end
            if (fire_taken) begin
                out_fire_valid = 1'b0;
            end
            cycles++;
        end
        if (time_update || out_fire_valid) begin
            errors++;
            $display("The DUT never took the time update and the output fire");
        end
        tx_expect.push_back(HDR_TIME);
        for (int i = 3; i >= 0; i--) begin
            tx_expect.push_back(now[i*8 +: 8]);
        end
        tx_expect.push_back(HDR_FIRE);
        tx_expect.push_back(addr);
        wait_for_log(LOG_TX, 7, "the time and fire reports");
        check_msg_bytes("reports");
        end_test("reports");
    endtask

    task automatic test_unknown(input logic [BYTE_W-1:0] n);
        send_byte(8'h10);
        send_byte(OP_STEP);
        send_byte(n);
        wait_for_log(LOG_STEP, 1, "the step request");
        repeat (6) @(negedge clk);
        check_count("step transfers", 1, step_log.size());
        if (step_log.size() > 0) begin
            check_byte("step_count", n, step_log[0]);
        end
        check_count("fire transfers", 0, fire_log.size());
        check_count("metric requests", 0, metric_log.size());
        check_msg_bytes("unknown tx");
        end_test("unknown opcode");
    endtask

    initial begin
        reset             = 1'b1;
        rx_data           = '0;
        rx_valid          = 1'b0;
        metric_value      = '0;
        metric_resp_valid = 1'b0;
        clear_done        = 1'b0;
        out_fire_addr     = '0;
        out_fire_valid    = 1'b0;
        time_current      = '0;
        time_update       = 1'b0;
        checks            = 0;
        errors            = 0;
        test_errors       = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_fire(7'h35, 8'hA7);
        test_step(8'h2C);
        test_metric(8'h41, 8'hD3);
        test_clear();
        test_reports(32'h1234_5678, 8'h9E);
        test_unknown(8'h07);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
logic/packet_pkg.sv
logic/rx_decoder.sv
logic/event_reporter.sv
logic/tx_link_arbiter.sv
logic/packet_interface.sv
dv/packet_interface_checker.sv
dv/packet_interface_tb.sv

// File: Makefile
# Verilator build and run of the host packet interface testbench

LOG = sim.log

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
		--top-module packet_interface_tb -o packet_interface_sim

# An aborted run counts as a failure
run: compile
	./obj_dir/packet_interface_sim > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: compile run clean
